//--- logic/blk_raster_pkg.sv
package blk_raster_pkg;

    localparam int PIX_W = 8;
    typedef logic [PIX_W-1:0] pix_t;

    localparam int IMG_W = 320;
    localparam int IMG_H = 240;

    localparam int BLK       = 8;            // block side
    localparam int BLK_PIX   = BLK * BLK;
    localparam int BLK_COLS  = IMG_W / BLK;
    localparam int BLK_ROWS  = IMG_H / BLK;
    localparam int BANK_PIX  = BLK_COLS * BLK_PIX; // one full block row
    localparam int NUM_LANES = BLK;          // one lane per pixel row in a block

    typedef logic [$clog2(IMG_W)-1:0] col_t;
    typedef logic [$clog2(IMG_W):0]   lane_addr_t; // bank bit on top of column

    // two banks of one image line each
    localparam int LANE_DEPTH = 2 * IMG_W;

    typedef logic [$clog2(NUM_LANES)-1:0] lane_sel_t;
    typedef logic [$clog2(BLK_ROWS)-1:0]  row_cnt_t;

endpackage

//--- logic/lane_if.sv
`timescale 1ns/1ps

interface lane_if;
    import blk_raster_pkg::*;

    logic       wr_en;
    lane_addr_t wr_addr;
    pix_t       wr_data;

    logic       rd_en;
    lane_addr_t rd_addr;
    pix_t       rd_data; // valid the cycle after rd_en

    modport fill (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport drain (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    modport store (
        input  wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

//--- logic/block_scatter.sv
`timescale 1ns/1ps

module block_scatter (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 en_i,
    input  logic                 pix_valid_i,
    input  blk_raster_pkg::pix_t pix_i,
    lane_if.fill                 lanes_o [blk_raster_pkg::NUM_LANES],
    output logic                 bank_full_o,
    output logic                 full_bank_o
);
    import blk_raster_pkg::*;

    typedef logic [$clog2(BANK_PIX)-1:0] fill_t;

    logic       accept;
    fill_t      fill_cnt;   // block column above offset in block
    row_cnt_t   blk_row;
    logic       bank;       // bank being filled
    logic       row_end;
    logic       row_done_q;
    logic       wr_en_q;
    lane_sel_t  wr_lane_q;
    lane_addr_t wr_addr_q;
    pix_t       wr_data_q;

    assign accept  = pix_valid_i & en_i;
    assign row_end = (fill_cnt == fill_t'(BANK_PIX - 1));

    // write port register, one cycle behind acceptance
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wr_lane_q <= fill_cnt[$clog2(BLK_PIX)-1:$clog2(BLK)]; // row inside block
            wr_addr_q <= {bank,
                          fill_cnt[$bits(fill_t)-1:$clog2(BLK_PIX)],
                          fill_cnt[$clog2(BLK)-1:0]};
            wr_data_q <= pix_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fill_cnt    <= '0;
            blk_row     <= '0;
            bank        <= 1'b0;
            full_bank_o <= 1'b0;
            row_done_q  <= 1'b0;
            bank_full_o <= 1'b0;
        end else begin
            row_done_q  <= accept & row_end;
            bank_full_o <= row_done_q; // cycle after the last write
            if (accept) begin
                if (row_end) begin
                    fill_cnt    <= '0;
                    full_bank_o <= bank;
                    if (blk_row == row_cnt_t'(BLK_ROWS - 1)) begin
                        blk_row <= '0; // frame end, restart on bank 0
                        bank    <= 1'b0;
                    end else begin
                        blk_row <= blk_row + 1'b1;
                        bank    <= ~bank;
                    end
                end else begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lanes_o[g].wr_en   = wr_en_q & (wr_lane_q == lane_sel_t'(g));
        assign lanes_o[g].wr_addr = wr_addr_q;
        assign lanes_o[g].wr_data = wr_data_q;
    end

endmodule

//--- logic/line_lane.sv
`timescale 1ns/1ps

module line_lane (
    input logic   clk_i,
    lane_if.store lane_i
);
    import blk_raster_pkg::*;

    pix_t       mem [LANE_DEPTH];
    lane_addr_t wr_idx;
    lane_addr_t rd_idx;

    // bank 1 sits right above bank 0
    function automatic lane_addr_t to_index(lane_addr_t addr);
        col_t col;
        col = addr[$bits(col_t)-1:0];
        return addr[$bits(col_t)] ? lane_addr_t'(IMG_W) + lane_addr_t'(col)
                                  : lane_addr_t'(col);
    endfunction

    assign wr_idx = to_index(lane_i.wr_addr);
    assign rd_idx = to_index(lane_i.rd_addr);

    always_ff @(posedge clk_i) begin
        if (lane_i.wr_en) begin
            mem[wr_idx] <= lane_i.wr_data;
        end
    end

    // registered read
    always_ff @(posedge clk_i) begin
        if (lane_i.rd_en) begin
            lane_i.rd_data <= mem[rd_idx];
        end
    end

endmodule

//--- logic/raster_gather.sv
`timescale 1ns/1ps

module raster_gather (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 bank_full_i,
    input  logic                 full_bank_i,
    input  logic                 pix_accept_i,
    lane_if.drain                lanes_i [blk_raster_pkg::NUM_LANES],
    output logic                 pix_valid_o,
    output blk_raster_pkg::pix_t pix_o,
    output logic                 frame_done_o
);
    import blk_raster_pkg::*;

    logic      rd_active;
    lane_sel_t rd_lane;
    col_t      rd_col;
    logic      rd_bank;
    logic      rd_last;      // final read of a block row
    lane_sel_t out_lane_q;
    logic      frame_last_q;
    row_cnt_t  row_cnt;      // block rows drained in this frame
    pix_t      lane_data [NUM_LANES];

    assign rd_last = rd_active
                     && (rd_lane == lane_sel_t'(NUM_LANES - 1))
                     && (rd_col == col_t'(IMG_W - 1));

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lanes_i[g].rd_en   = rd_active & (rd_lane == lane_sel_t'(g));
        assign lanes_i[g].rd_addr = {rd_bank, rd_col};
        assign lane_data[g]       = lanes_i[g].rd_data;
    end

    assign pix_o = lane_data[out_lane_q];

    // one lane across the whole line, then the next lane
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_active <= 1'b0;
            rd_lane   <= '0;
            rd_col    <= '0;
            rd_bank   <= 1'b0;
        end else if (bank_full_i) begin
            rd_active <= 1'b1;
            rd_lane   <= '0;
            rd_col    <= '0;
            rd_bank   <= full_bank_i;
        end else if (rd_active) begin
            if (rd_col == col_t'(IMG_W - 1)) begin
                rd_col  <= '0;
                rd_lane <= rd_lane + 1'b1;
                if (rd_lane == lane_sel_t'(NUM_LANES - 1)) begin
                    rd_active <= 1'b0; // bank drained
                end
            end else begin
                rd_col <= rd_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pix_valid_o  <= 1'b0;
            out_lane_q   <= '0;
            frame_last_q <= 1'b0;
            row_cnt      <= '0;
            frame_done_o <= 1'b0;
        end else begin
            pix_valid_o  <= rd_active; // data comes out of the lane now
            out_lane_q   <= rd_lane;
            frame_last_q <= rd_last && (row_cnt == row_cnt_t'(BLK_ROWS - 1));
            if (rd_last) begin
                row_cnt <= (row_cnt == row_cnt_t'(BLK_ROWS - 1)) ? '0 : row_cnt + 1'b1;
            end
            if (frame_last_q) begin
                frame_done_o <= 1'b1;
            end else if (pix_accept_i) begin
                frame_done_o <= 1'b0; // next frame has begun
            end
        end
    end

endmodule

//--- logic/blk_raster_top.sv
`timescale 1ns/1ps

module blk_raster_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 en_i,
    input  logic                 pix_valid_i,
    input  blk_raster_pkg::pix_t pix_i,
    output logic                 pix_valid_o,
    output blk_raster_pkg::pix_t pix_o,
    output logic                 frame_done_o
);
    import blk_raster_pkg::*;

    logic pix_accept;
    logic bank_full;
    logic full_bank;

    lane_if lanes [NUM_LANES] ();

    // input rate is at most one pixel per clock
    assign pix_accept = pix_valid_i & en_i;

    block_scatter u_scatter (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .lanes_o     (lanes),
        .bank_full_o (bank_full),
        .full_bank_o (full_bank)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        line_lane u_lane (
            .clk_i  (clk_i),
            .lane_i (lanes[g])
        );
    end

    raster_gather u_gather (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bank_full_i  (bank_full),
        .full_bank_i  (full_bank),
        .pix_accept_i (pix_accept),
        .lanes_i      (lanes),
        .pix_valid_o  (pix_valid_o),
        .pix_o        (pix_o),
        .frame_done_o (frame_done_o)
    );

endmodule

//--- testbench/tb_blk_raster.sv
`timescale 1ns/1ps

module tb_blk_raster;
    import blk_raster_pkg::*;

    localparam int FRAME_PIX     = IMG_W * IMG_H;
    localparam int DRAIN_TIMEOUT = 4 * BANK_PIX; // cycles
    localparam int NUM_TESTS     = 5;
    localparam logic PAT_INC     = 1'b0;
    localparam logic PAT_RAND    = 1'b1;

    typedef struct packed {
        logic        pattern;   // PAT_INC or PAT_RAND
        logic        gaps;      // 0 to 3 idle cycles between strobes
        logic        garbage;   // extra strobes with en_i low
        logic        wait_done; // drain the frame before the next row
        logic [31:0] exp_pix;   // outputs expected for the frame
    } test_row_t;

    // rows 3 and 4 run back to back
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{PAT_INC,  1'b0, 1'b0, 1'b1, FRAME_PIX},
        '{PAT_RAND, 1'b1, 1'b0, 1'b1, FRAME_PIX},
        '{PAT_INC,  1'b1, 1'b1, 1'b1, FRAME_PIX},
        '{PAT_RAND, 1'b0, 1'b0, 1'b0, FRAME_PIX},
        '{PAT_INC,  1'b0, 1'b0, 1'b1, FRAME_PIX}
    };

    logic   clk_i;
    logic   rst_i;
    logic   en_i;
    logic   pix_valid_i;
    pix_t   pix_i;
    logic   pix_valid_o;
    pix_t   pix_o;
    logic   frame_done_o;

    integer seed = 32'h6c80_fb70;
    int     errors = 0;
    int     cyc = 0;          // rising edges seen
    int     in_cnt = 0;
    int     out_cnt = 0;
    int     frames_out = 0;
    int     blk_rows_in = 0;
    int     last_out_cyc = 0;
    logic   exp_done = 1'b0;
    logic   done_set_pend = 1'b0;
    logic   done_clr_pend = 1'b0;
    int     row_done_cyc [$]; // expected edge of each block row's first output
    pix_t   exp_raster [FRAME_PIX];

    blk_raster_top dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .pix_valid_i  (pix_valid_i),
        .pix_i        (pix_i),
        .pix_valid_o  (pix_valid_o),
        .pix_o        (pix_o),
        .frame_done_o (frame_done_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("ERROR: timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic drive_idle();
        pix_valid_i = 1'b0;
        en_i        = 1'($random(seed)); // en alone must not count
        pix_i       = pix_t'($random(seed));
        next_cycle();
    endtask

    task automatic send_frame(input test_row_t t);
        int   gap;
        pix_t val;
        for (int k = 0; k < FRAME_PIX; k++) begin
            // first one lands while done is still high
            if (t.garbage && (k == 0 || ($random(seed) & 3) == 0)) begin
                pix_valid_i = 1'b1;
                en_i        = 1'b0;
                pix_i       = pix_t'($random(seed));
                next_cycle();
            end
            gap = t.gaps ? ($random(seed) & 3) : 0;
            repeat (gap) drive_idle();
            val = (t.pattern == PAT_RAND) ? pix_t'($random(seed)) : pix_t'(k);
            pix_valid_i = 1'b1;
            en_i        = 1'b1;
            pix_i       = val;
            next_cycle();
        end
        pix_valid_i = 1'b0;
        en_i        = 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int t;
        t = 0;
        while (frames_out < target && t < DRAIN_TIMEOUT) begin
            next_cycle();
            t++;
        end
        if (frames_out < target) begin
            fail_timeout("the last output pixel of a frame");
        end
    endtask

    task automatic wait_done_level();
        int t;
        t = 0;
        while (frame_done_o !== 1'b1 && t < DRAIN_TIMEOUT) begin
            next_cycle();
            t++;
        end
        if (frame_done_o !== 1'b1) begin
            fail_timeout("frame_done_o to rise");
        end
    endtask

    // reference model and output checks, sampled mid cycle
    always @(negedge clk_i) begin : monitor
        int k;
        int b;
        int p;
        int row;
        int col;
        int pos;
        int first_cyc;
        if (!rst_i) begin
            if (done_set_pend) begin
                exp_done = 1'b1;
            end else if (done_clr_pend) begin
                exp_done = 1'b0;
            end
            done_set_pend = 1'b0;
            done_clr_pend = 1'b0;
            check_eq(32'(frame_done_o), 32'(exp_done), "frame_done_o");

            if (pix_valid_i && en_i) begin // accepted at the next edge
                k   = in_cnt % FRAME_PIX;
                b   = k / BLK_PIX;
                p   = k % BLK_PIX;
                row = (b / BLK_COLS) * BLK + p / BLK;
                col = (b % BLK_COLS) * BLK + p % BLK;
                exp_raster[row * IMG_W + col] = pix_i;
                if (p == BLK_PIX - 1 && b % BLK_COLS == BLK_COLS - 1) begin
                    row_done_cyc.push_back(cyc + 4);
                    blk_rows_in++;
                end
                in_cnt++;
                done_clr_pend = 1'b1;
            end

            if (pix_valid_o) begin
                check_eq(32'(out_cnt < blk_rows_in * BANK_PIX), 32'd1,
                         "output before its block row was complete");
                pos = out_cnt % FRAME_PIX;
                if (pos % BANK_PIX == 0) begin
                    first_cyc = row_done_cyc.pop_front();
                    check_eq(32'(cyc), 32'(first_cyc), "cycle of first block row output");
                end else begin
                    check_eq(32'(cyc), 32'(last_out_cyc + 1), "gap inside block row output");
                end
                check_eq(32'(pix_o), 32'(exp_raster[pos]),
                         $sformatf("pix_o at raster index %0d", pos));
                last_out_cyc = cyc;
                out_cnt++;
                if (pos == FRAME_PIX - 1) begin
                    frames_out++;
                    done_set_pend = 1'b1;
                end
            end
        end
    end

    initial begin : main
        int total;
        total       = 0;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        en_i        = 1'b0;
        pix_valid_i = 1'b0;
        pix_i       = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        repeat (3) drive_idle();

        for (int i = 0; i < NUM_TESTS; i++) begin
            $display("test %0d: pattern %0d gaps %0d garbage %0d", i,
                     TESTS[i].pattern, TESTS[i].gaps, TESTS[i].garbage);
            send_frame(TESTS[i]);
            total = total + int'(TESTS[i].exp_pix);
            if (TESTS[i].wait_done) begin
                wait_frames(i + 1);
                wait_done_level();
                check_eq(32'(out_cnt), 32'(total), "output pixel count");
                repeat (5) drive_idle(); // done must hold while idle
            end
        end

        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- blk_raster_top.f
logic/blk_raster_pkg.sv
logic/lane_if.sv
logic/block_scatter.sv
logic/line_lane.sv
logic/raster_gather.sv
logic/blk_raster_top.sv
testbench/tb_blk_raster.sv

//--- Makefile
# Verilator build and run for the block to raster reorder

SIM = obj_dir/Vtb_blk_raster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 --top-module tb_blk_raster -f blk_raster_top.f -Mdir obj_dir

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
